// File: naive_pipe_macros.svh
`ifndef NAIVE_PIPE_MACROS_SVH
`define NAIVE_PIPE_MACROS_SVH

`define NP_RESET_PC     32'hbfc0_0000
`define NP_NOP_WORD     32'h0000_0000
`define NP_REG_ZERO     5'd0

// primary opcode field, inst[31:26]
`define NP_OPC_SPECIAL  6'h00
`define NP_OPC_BEQ      6'h04
`define NP_OPC_BNE      6'h05
`define NP_OPC_ADDIU    6'h09
`define NP_OPC_ORI      6'h0d
`define NP_OPC_LUI      6'h0f
`define NP_OPC_LW       6'h23
`define NP_OPC_SW       6'h2b

// function field of SPECIAL, inst[5:0]
`define NP_FN_ADDU      6'h21
`define NP_FN_SUBU      6'h23
`define NP_FN_AND       6'h24
`define NP_FN_OR        6'h25
`define NP_FN_SLT       6'h2a

`define NP_ALU_ADD      3'd0
`define NP_ALU_SUB      3'd1
`define NP_ALU_AND      3'd2
`define NP_ALU_OR       3'd3
`define NP_ALU_SLT      3'd4
`define NP_ALU_LUI      3'd5    // passes the pre-shifted immediate

`endif

// File: naive_pipe_pkg.sv
package naive_pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;

    // decode -> execute
    typedef struct packed {
        alu_op_t  alu_op;
        logic     use_imm;     // operand b comes from imm
        word_t    imm;         // already extended
        word_t    op_a;
        word_t    op_b;
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_we;
        logic     mem_rd;
        logic     mem_wr;
    } id_ex_t;

    typedef struct packed {
        word_t    result;      // alu result or memory address
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_we;
        logic     mem_rd;
        logic     mem_wr;
    } ex_mm_t;

    typedef struct packed {
        word_t    value;
        reg_idx_t dest;
        logic     reg_we;
    } mm_wb_t;

    typedef struct packed {
        word_t address;
        word_t wrdata;
        logic  read;
        logic  write;
    } dbus_req_t;

endpackage

// File: reg_file.sv
`include "naive_pipe_macros.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  naive_pipe_pkg::reg_idx_t raddr_a_i,
    input  naive_pipe_pkg::reg_idx_t raddr_b_i,
    output naive_pipe_pkg::word_t    rdata_a_o,
    output naive_pipe_pkg::word_t    rdata_b_o,
    input  logic                     we_i,
    input  naive_pipe_pkg::reg_idx_t waddr_i,
    input  naive_pipe_pkg::word_t    wdata_i
);

    naive_pipe_pkg::word_t regs [32];
    logic wr_hit;

    assign wr_hit = we_i && (waddr_i != `NP_REG_ZERO);

    always_ff @(posedge clk) begin
        if (rst_n && wr_hit) begin   // no writes while in reset
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is visible to the reader in decode
    assign rdata_a_o = (raddr_a_i == `NP_REG_ZERO) ? '0 :
                       (wr_hit && waddr_i == raddr_a_i) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == `NP_REG_ZERO) ? '0 :
                       (wr_hit && waddr_i == raddr_b_i) ? wdata_i : regs[raddr_b_i];

endmodule

// File: inst_decode.sv
`include "naive_pipe_macros.svh"

module inst_decode (
    input  naive_pipe_pkg::word_t    inst_i,
    input  naive_pipe_pkg::word_t    pc_i,
    input  naive_pipe_pkg::word_t    rs_val_i,
    input  naive_pipe_pkg::word_t    rt_val_i,
    output naive_pipe_pkg::reg_idx_t rs_o,
    output naive_pipe_pkg::reg_idx_t rt_o,
    output naive_pipe_pkg::id_ex_t   decoded_o,
    output logic                     branch_taken_o,
    output naive_pipe_pkg::word_t    branch_target_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm16;
    naive_pipe_pkg::word_t imm_sext;

    assign opcode   = inst_i[31:26];
    assign funct    = inst_i[5:0];
    assign imm16    = inst_i[15:0];
    assign rs_o     = inst_i[25:21];
    assign rt_o     = inst_i[20:16];
    assign imm_sext = {{16{imm16[15]}}, imm16};

    // target is relative to the delay slot
    assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        decoded_o            = '0;
        decoded_o.alu_op     = `NP_ALU_ADD;
        decoded_o.imm        = imm_sext;
        decoded_o.op_a       = rs_val_i;
        decoded_o.op_b       = rt_val_i;
        decoded_o.store_data = rt_val_i;
        decoded_o.dest       = rt_o;
        branch_taken_o       = 1'b0;
        case (opcode)
            `NP_OPC_SPECIAL: begin
                decoded_o.dest   = inst_i[15:11];
                decoded_o.reg_we = 1'b1;
                case (funct)
                    `NP_FN_ADDU: decoded_o.alu_op = `NP_ALU_ADD;
                    `NP_FN_SUBU: decoded_o.alu_op = `NP_ALU_SUB;
                    `NP_FN_AND:  decoded_o.alu_op = `NP_ALU_AND;
                    `NP_FN_OR:   decoded_o.alu_op = `NP_ALU_OR;
                    `NP_FN_SLT:  decoded_o.alu_op = `NP_ALU_SLT;
                    default:     decoded_o.reg_we = 1'b0;   // sll 0 etc. as no-op
                endcase
            end
            `NP_OPC_ADDIU: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
            end
            `NP_OPC_ORI: begin
                decoded_o.alu_op  = `NP_ALU_OR;
                decoded_o.use_imm = 1'b1;
                decoded_o.imm     = {16'h0000, imm16};
                decoded_o.reg_we  = 1'b1;
            end
            `NP_OPC_LUI: begin
                decoded_o.alu_op  = `NP_ALU_LUI;
                decoded_o.use_imm = 1'b1;
                decoded_o.imm     = {imm16, 16'h0000};
                decoded_o.reg_we  = 1'b1;
            end
            `NP_OPC_LW: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
                decoded_o.mem_rd  = 1'b1;
            end
            `NP_OPC_SW: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.mem_wr  = 1'b1;
            end
            `NP_OPC_BEQ: branch_taken_o = (rs_val_i == rt_val_i);
            `NP_OPC_BNE: branch_taken_o = (rs_val_i != rt_val_i);
            default: ;
        endcase
    end

endmodule

// File: operand_fwd.sv
`include "naive_pipe_macros.svh"

module operand_fwd (
    input  naive_pipe_pkg::reg_idx_t reg_i,
    input  naive_pipe_pkg::word_t    regs_val_i,
    input  naive_pipe_pkg::ex_mm_t   ex_fwd_i,
    input  naive_pipe_pkg::mm_wb_t   mm_fwd_i,
    output naive_pipe_pkg::word_t    value_o
);

    logic hit_ex;
    logic hit_mm;

    assign hit_ex = ex_fwd_i.reg_we && (ex_fwd_i.dest == reg_i);
    assign hit_mm = mm_fwd_i.reg_we && (mm_fwd_i.dest == reg_i);

    // writeback needs no path here, the register file bypasses it
    always_comb begin
        if (reg_i == `NP_REG_ZERO) begin
            value_o = regs_val_i;
        end else if (hit_ex) begin
            value_o = ex_fwd_i.result;   // youngest writer wins
        end else if (hit_mm) begin
            value_o = mm_fwd_i.value;
        end else begin
            value_o = regs_val_i;
        end
    end

endmodule

// File: alu_exec.sv
`include "naive_pipe_macros.svh"

module alu_exec (
    input  naive_pipe_pkg::id_ex_t stage_i,
    output naive_pipe_pkg::ex_mm_t result_o
);

    naive_pipe_pkg::word_t opd_a;
    naive_pipe_pkg::word_t opd_b;
    naive_pipe_pkg::word_t res;

    assign opd_a = stage_i.op_a;
    assign opd_b = stage_i.use_imm ? stage_i.imm : stage_i.op_b;

    always_comb begin
        case (stage_i.alu_op)
            `NP_ALU_ADD: res = opd_a + opd_b;   // also lw/sw address
            `NP_ALU_SUB: res = opd_a - opd_b;
            `NP_ALU_AND: res = opd_a & opd_b;
            `NP_ALU_OR:  res = opd_a | opd_b;
            `NP_ALU_SLT: res = {31'd0, $signed(opd_a) < $signed(opd_b)};
            `NP_ALU_LUI: res = opd_b;
            default:     res = '0;
        endcase
    end

    always_comb begin
        result_o.result     = res;
        result_o.store_data = stage_i.store_data;
        result_o.dest       = stage_i.dest;
        result_o.reg_we     = stage_i.reg_we;
        result_o.mem_rd     = stage_i.mem_rd;
        result_o.mem_wr     = stage_i.mem_wr;
    end

endmodule

// File: hazard_ctl.sv
`include "naive_pipe_macros.svh"

module hazard_ctl (
    input  logic                     ibus_stall_i,
    input  logic                     dbus_stall_i,
    input  logic                     ex_mem_rd_i,
    input  naive_pipe_pkg::reg_idx_t ex_dest_i,
    input  naive_pipe_pkg::reg_idx_t id_rs_i,
    input  naive_pipe_pkg::reg_idx_t id_rt_i,
    output logic                     en_pc_o,
    output logic                     en_ifid_o,
    output logic                     en_idex_o,
    output logic                     en_exmm_o,
    output logic                     en_mmwb_o,
    output logic                     bubble_o
);

    logic load_use;

    assign load_use = ex_mem_rd_i && (ex_dest_i != `NP_REG_ZERO) &&
                      (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

    always_comb begin
        if (dbus_stall_i) begin
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o, bubble_o} = 6'b00000_0;
        end else if (load_use || ibus_stall_i) begin
            // hold fetch and decode, back end keeps draining
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o, bubble_o} = 6'b00111_1;
        end else begin
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o, bubble_o} = 6'b11111_0;
        end
    end

endmodule

// File: naive_pipe.sv
`include "naive_pipe_macros.svh"

module naive_pipe (
    input  logic                      clk,
    input  logic                      rst_n,
    output naive_pipe_pkg::word_t     ibus_address_o,
    output logic                      ibus_read_o,
    input  naive_pipe_pkg::word_t     ibus_rddata_i,
    input  logic                      ibus_stall_i,
    output naive_pipe_pkg::dbus_req_t dbus_req_o,
    input  naive_pipe_pkg::word_t     dbus_rddata_i,
    input  logic                      dbus_stall_i
);

    logic en_pc, en_ifid, en_idex, en_exmm, en_mmwb, bubble;

    naive_pipe_pkg::word_t    pc;
    naive_pipe_pkg::word_t    if_id_inst;
    naive_pipe_pkg::word_t    if_id_pc;
    naive_pipe_pkg::reg_idx_t id_rs, id_rt;
    naive_pipe_pkg::word_t    rs_regs, rt_regs;
    naive_pipe_pkg::word_t    rs_val, rt_val;
    naive_pipe_pkg::id_ex_t   id_decoded;
    logic                     branch_taken;
    naive_pipe_pkg::word_t    branch_target;

    naive_pipe_pkg::id_ex_t   id_ex;
    naive_pipe_pkg::ex_mm_t   ex_result;
    naive_pipe_pkg::ex_mm_t   ex_mm;
    naive_pipe_pkg::mm_wb_t   mm_result;
    naive_pipe_pkg::mm_wb_t   mm_wb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `NP_RESET_PC;
        end else if (en_pc) begin
            pc <= branch_taken ? branch_target : pc + 32'd4;
        end
    end

    assign ibus_address_o = pc;
    assign ibus_read_o    = rst_n;   // fetch runs from the first cycle out of reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id_inst <= `NP_NOP_WORD;
            if_id_pc   <= `NP_RESET_PC;
        end else if (en_ifid) begin
            if_id_inst <= ibus_rddata_i;
            if_id_pc   <= pc;
        end
    end

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (rs_regs),
        .rdata_b_o (rt_regs),
        .we_i      (mm_wb.reg_we),
        .waddr_i   (mm_wb.dest),
        .wdata_i   (mm_wb.value)
    );

    operand_fwd fwd_rs_inst (
        .reg_i      (id_rs),
        .regs_val_i (rs_regs),
        .ex_fwd_i   (ex_result),
        .mm_fwd_i   (mm_result),
        .value_o    (rs_val)
    );

    operand_fwd fwd_rt_inst (
        .reg_i      (id_rt),
        .regs_val_i (rt_regs),
        .ex_fwd_i   (ex_result),
        .mm_fwd_i   (mm_result),
        .value_o    (rt_val)
    );

    inst_decode inst_decode_inst (
        .inst_i          (if_id_inst),
        .pc_i            (if_id_pc),
        .rs_val_i        (rs_val),
        .rt_val_i        (rt_val),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .decoded_o       (id_decoded),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (en_idex) begin
            id_ex <= bubble ? '0 : id_decoded;   // bubble is an all-zero no-op
        end
    end

    alu_exec alu_exec_inst (
        .stage_i  (id_ex),
        .result_o (ex_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mm <= '0;
        end else if (en_exmm) begin
            ex_mm <= ex_result;
        end
    end

    // load data is only valid while dbus is not stalling
    assign mm_result.value  = ex_mm.mem_rd ? dbus_rddata_i : ex_mm.result;
    assign mm_result.dest   = ex_mm.dest;
    assign mm_result.reg_we = ex_mm.reg_we;

    assign dbus_req_o.address = ex_mm.result;
    assign dbus_req_o.wrdata  = ex_mm.store_data;
    assign dbus_req_o.read    = ex_mm.mem_rd;
    assign dbus_req_o.write   = ex_mm.mem_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_wb <= '0;
        end else if (en_mmwb) begin
            mm_wb <= mm_result;
        end
    end

    hazard_ctl hazard_ctl_inst (
        .ibus_stall_i (ibus_stall_i),
        .dbus_stall_i (dbus_stall_i),
        .ex_mem_rd_i  (id_ex.mem_rd),
        .ex_dest_i    (id_ex.dest),
        .id_rs_i      (id_rs),
        .id_rt_i      (id_rt),
        .en_pc_o      (en_pc),
        .en_ifid_o    (en_ifid),
        .en_idex_o    (en_idex),
        .en_exmm_o    (en_exmm),
        .en_mmwb_o    (en_mmwb),
        .bubble_o     (bubble)
    );

endmodule

// File: naive_pipe_assertions.sv
module naive_pipe_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input naive_pipe_pkg::word_t     ibus_address_o,
    input logic                      ibus_read_o,
    input logic                      ibus_stall_i,
    input naive_pipe_pkg::dbus_req_t dbus_req_o,
    input logic                      dbus_stall_i
);

    // a stalled data request is held until accepted
    dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_req_o.read || dbus_req_o.write) && dbus_stall_i |=> $stable(dbus_req_o))
        else $error("dbus request changed during stall");

    dbus_rw_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_req_o.read && dbus_req_o.write))
        else $error("dbus read and write both high");

    ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_read_o && ibus_stall_i |=> $stable(ibus_address_o))
        else $error("ibus address changed during stall");

endmodule

bind naive_pipe naive_pipe_assertions naive_pipe_assertions_inst (.*);

// File: tb_naive_pipe.sv
`include "naive_pipe_macros.svh"

module tb_naive_pipe;

    localparam int N_TESTS = 9;
    localparam int RUN_LIMIT = 1500;   // cycles allowed per program

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    naive_pipe_pkg::word_t     ibus_address, ibus_rddata, dbus_rddata;
    naive_pipe_pkg::dbus_req_t dbus_req;
    logic ibus_read;
    logic ibus_stall = 1'b0;
    logic dbus_stall = 1'b0;
    logic stall_en = 1'b0;
    logic done_seen = 1'b0;
    logic [31:0] lfsr = 32'h1034_3ac8;

    naive_pipe_pkg::word_t imem [256];
    naive_pipe_pkg::word_t dmem [256];
    int store_cnt [256];
    int prog_len;
    int errors = 0;
    int failed_tests = 0;

    always #4 clk = ~clk;

    naive_pipe naive_pipe_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address),
        .ibus_read_o    (ibus_read),
        .ibus_rddata_i  (ibus_rddata),
        .ibus_stall_i   (ibus_stall),
        .dbus_req_o     (dbus_req),
        .dbus_rddata_i  (dbus_rddata),
        .dbus_stall_i   (dbus_stall)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic naive_pipe_pkg::word_t rtype_word(
        input int rs, input int rt, input int rd, input logic [5:0] fn);
        return {`NP_OPC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic naive_pipe_pkg::word_t itype_word(
        input logic [5:0] opc, input int rs, input int rt, input logic [15:0] imm);
        return {opc, rs[4:0], rt[4:0], imm};
    endfunction

    // word-addressed memory models with imem based at the reset PC
    always_comb begin
        if (ibus_read && ((ibus_address - `NP_RESET_PC) >> 2) < 256)
            ibus_rddata = imem[(ibus_address - `NP_RESET_PC) >> 2];
        else
            ibus_rddata = `NP_NOP_WORD;
        dbus_rddata = dbus_req.read ? dmem[dbus_req.address[9:2]] : '0;
    end

    always @(posedge clk) begin
        if (rst_n && dbus_req.write && !dbus_stall) begin
            dmem[dbus_req.address[9:2]] = dbus_req.wrdata;
            store_cnt[dbus_req.address[9:2]] = store_cnt[dbus_req.address[9:2]] + 1;
            if (dbus_req.address == 32'h100) done_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (stall_en) begin
            #1;
            lfsr = lfsr_next(lfsr);
            ibus_stall = lfsr[0];
            lfsr = lfsr_next(lfsr);
            dbus_stall = lfsr[0];
        end else begin
            #1;
            ibus_stall = 1'b0;
            dbus_stall = 1'b0;
        end
    end

    initial begin
        #(N_TESTS * 2000 * 8);
        $display("timeout: the tests did not finish in the allowed time");
        $display("Regression failed");
        $finish;
    end

    task automatic emit(input naive_pipe_pkg::word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic new_program();
        for (int i = 0; i < 256; i++) imem[i] = `NP_NOP_WORD;
        prog_len = 0;
    endtask

    // holds reset for 16 cycles and checks the idle buses before release
    task automatic apply_reset(input logic stalls);
        stall_en = 1'b0;
        rst_n = 1'b0;
        done_seen = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {16'hc3a5, i[15:0]};   // fill depends on the index
            store_cnt[i] = 0;
        end
        repeat (16) begin
            @(posedge clk);
            #1;
            if (dbus_req.read || dbus_req.write) begin
                $display("error: dbus_req read/write expected 0 got %h",
                         {dbus_req.read, dbus_req.write});
                errors++;
            end
            if (ibus_read) begin
                $display("error: ibus_read_o expected 0 got %h", ibus_read);
                errors++;
            end
        end
        rst_n = 1'b1;
        if (ibus_address != `NP_RESET_PC) begin
            $display("error: ibus_address_o expected %h got %h", `NP_RESET_PC, ibus_address);
            errors++;
        end
        stall_en = stalls;
    endtask

    task automatic run_program(input logic stalls);
        int cycles;
        emit(itype_word(`NP_OPC_SW, 0, 0, 16'h0100));   // done marker
        apply_reset(stalls);
        cycles = 0;
        while (!done_seen && cycles < RUN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done_seen) begin
            $display("program never stored to the done address");
            errors++;
        end
        stall_en = 1'b0;
    endtask

    task automatic expect_word(input int addr, input naive_pipe_pkg::word_t exp, input string sig);
        if (dmem[addr >> 2] !== exp) begin
            $display("error: %s expected %h got %h", sig, exp, dmem[addr >> 2]);
            errors++;
        end
        if (store_cnt[addr >> 2] != 1) begin
            $display("store to address %h was seen %0d times instead of once",
                     addr, store_cnt[addr >> 2]);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED", name);
            failed_tests++;
        end
    endtask

    task automatic reset_state();
        int e0;
        e0 = errors;
        new_program();
        apply_reset(1'b0);
        @(posedge clk);
        #1;
        if (ibus_read !== 1'b1) begin
            $display("error: ibus_read_o expected 1 got %h", ibus_read);
            errors++;
        end
        if (dbus_req.read || dbus_req.write) begin
            $display("error: dbus_req read/write expected 0 got %h",
                     {dbus_req.read, dbus_req.write});
            errors++;
        end
        if (ibus_address != `NP_RESET_PC + 32'd4) begin   // first fetch taken
            $display("error: ibus_address_o expected %h got %h",
                     `NP_RESET_PC + 32'd4, ibus_address);
            errors++;
        end
        report_test("reset", e0);
    endtask

    task automatic arith_ops(input logic stalls);
        int e0;
        naive_pipe_pkg::word_t v [11];
        e0 = errors;
        new_program();
        emit(itype_word(`NP_OPC_ADDIU, 0, 1, 16'h1234));
        emit(itype_word(`NP_OPC_ADDIU, 0, 2, 16'hfffb));
        emit(itype_word(`NP_OPC_ORI, 0, 3, 16'h8001));
        emit(itype_word(`NP_OPC_LUI, 0, 4, 16'habcd));
        emit(rtype_word(1, 2, 5, `NP_FN_ADDU));
        emit(rtype_word(1, 2, 6, `NP_FN_SUBU));
        emit(rtype_word(2, 1, 7, `NP_FN_AND));
        emit(rtype_word(4, 3, 8, `NP_FN_OR));
        emit(rtype_word(2, 1, 9, `NP_FN_SLT));
        emit(rtype_word(1, 2, 10, `NP_FN_SLT));
        emit(itype_word(`NP_OPC_ADDIU, 0, 0, 16'h0007));   // r0 stays zero
        for (int r = 0; r <= 10; r++) emit(itype_word(`NP_OPC_SW, 0, r, 16'(r * 4)));
        run_program(stalls);
        v[0] = 32'h0;
        v[1] = 32'h0000_1234;
        v[2] = 32'hffff_fffb;   // sign extended
        v[3] = 32'h0000_8001;   // zero extended
        v[4] = 32'habcd_0000;
        v[5] = v[1] + v[2];
        v[6] = v[1] - v[2];
        v[7] = v[2] & v[1];
        v[8] = v[4] | v[3];
        v[9] = 32'd1;    // -5 is less than 0x1234
        v[10] = 32'd0;   // signed compare, 0x1234 is not less than -5
        for (int r = 0; r <= 10; r++) expect_word(r * 4, v[r], $sformatf("dmem r%0d", r));
        report_test(stalls ? "arith_stall" : "arith", e0);
    endtask

    task automatic forward_chain(input logic stalls);
        int e0;
        naive_pipe_pkg::word_t r1, r2, r3, r4, r5, r6;
        e0 = errors;
        new_program();
        emit(itype_word(`NP_OPC_ADDIU, 0, 1, 16'h0001));
        emit(itype_word(`NP_OPC_ADDIU, 1, 2, 16'h0003));
        emit(rtype_word(2, 1, 3, `NP_FN_ADDU));
        emit(rtype_word(3, 2, 4, `NP_FN_SUBU));
        emit(rtype_word(4, 3, 5, `NP_FN_OR));
        emit(rtype_word(5, 5, 6, `NP_FN_ADDU));
        emit(itype_word(`NP_OPC_SW, 0, 6, 16'h0000));
        emit(itype_word(`NP_OPC_SW, 0, 3, 16'h0004));
        run_program(stalls);
        r1 = 32'd1;
        r2 = r1 + 32'd3;
        r3 = r2 + r1;
        r4 = r3 - r2;
        r5 = r4 | r3;
        r6 = r5 + r5;
        expect_word(0, r6, "dmem r6");
        expect_word(4, r3, "dmem r3");
        report_test(stalls ? "forward_stall" : "forward", e0);
    endtask

    task automatic load_use_bubble(input logic stalls);
        int e0;
        naive_pipe_pkg::word_t r1;
        e0 = errors;
        new_program();
        emit(itype_word(`NP_OPC_ADDIU, 0, 1, 16'h0055));
        emit(itype_word(`NP_OPC_SW, 0, 1, 16'h0040));
        emit(itype_word(`NP_OPC_LW, 0, 2, 16'h0040));
        emit(rtype_word(2, 1, 3, `NP_FN_ADDU));
        emit(itype_word(`NP_OPC_SW, 0, 3, 16'h0000));
        emit(itype_word(`NP_OPC_LW, 0, 4, 16'h0040));
        emit(rtype_word(4, 4, 5, `NP_FN_ADDU));   // both operands wait on the load
        emit(itype_word(`NP_OPC_SW, 0, 5, 16'h0004));
        run_program(stalls);
        r1 = 32'h55;
        expect_word(32'h40, r1, "dmem 0x40");
        expect_word(0, r1 + r1, "dmem r3");
        expect_word(4, r1 + r1, "dmem r5");
        report_test(stalls ? "load_use_stall" : "load_use", e0);
    endtask

    task automatic branch_delay_slot(input logic stalls);
        int e0;
        e0 = errors;
        new_program();
        emit(itype_word(`NP_OPC_ADDIU, 0, 4, 16'h0001));
        emit(itype_word(`NP_OPC_ADDIU, 0, 5, 16'h0002));
        emit(itype_word(`NP_OPC_ADDIU, 0, 1, 16'h0005));
        emit(itype_word(`NP_OPC_ADDIU, 0, 2, 16'h0005));
        emit(itype_word(`NP_OPC_BEQ, 1, 2, 16'h0003));   // taken and skips two
        emit(itype_word(`NP_OPC_ADDIU, 0, 3, 16'h0011)); // delay slot
        emit(itype_word(`NP_OPC_ADDIU, 0, 4, 16'h0022));
        emit(itype_word(`NP_OPC_ADDIU, 0, 5, 16'h0033));
        emit(itype_word(`NP_OPC_ADDIU, 0, 6, 16'h0044));
        emit(itype_word(`NP_OPC_BNE, 1, 2, 16'h0002));   // not taken
        emit(itype_word(`NP_OPC_ADDIU, 0, 7, 16'h0055));
        emit(itype_word(`NP_OPC_ADDIU, 0, 8, 16'h0066));
        for (int r = 3; r <= 8; r++) emit(itype_word(`NP_OPC_SW, 0, r, 16'((r - 3) * 4)));
        run_program(stalls);
        expect_word(0, 32'h11, "dmem r3");
        expect_word(4, 32'h01, "dmem r4");
        expect_word(8, 32'h02, "dmem r5");
        expect_word(12, 32'h44, "dmem r6");
        expect_word(16, 32'h55, "dmem r7");
        expect_word(20, 32'h66, "dmem r8");
        report_test(stalls ? "branch_stall" : "branch", e0);
    endtask

    initial begin
        reset_state();
        for (int s = 0; s < 2; s++) begin
            arith_ops(s[0]);
            forward_chain(s[0]);
            load_use_bubble(s[0]);
            branch_delay_slot(s[0]);
        end
        $display("tests %0d, failed tests %0d, errors %0d", N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: naive_pipe.f
+incdir+.
naive_pipe_pkg.sv
reg_file.sv
inst_decode.sv
operand_fwd.sv
alu_exec.sv
hazard_ctl.sv
naive_pipe.sv
naive_pipe_assertions.sv
tb_naive_pipe.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_naive_pipe
FILELIST  ?= naive_pipe.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
